/* Makefile */
# Verilator build and run of the core testbench

sim:
	verilator --binary --timing --top-module tb_core_top -f core_top.f
	@out="$$(./obj_dir/Vtb_core_top)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* alu.sv */
module alu
    import core_pipe_pkg::*;
(
    input  alu_op_t op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];                  // RV32 shift amount
    assign lt_signed   = ($signed(a_i) < $signed(b_i));
    assign lt_unsigned = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = word_t'(lt_signed);
            ALU_SLTU:   result_o = word_t'(lt_unsigned);
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

/* core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ================================================
// Core sizing
// ================================================

`define XLEN        32              // Data path width

`define NUM_REGS    32              // Architectural registers, x0 included

// Instruction buffer entries
// Also the number of credits the source holds after reset
`define QUEUE_DEPTH 4

// ================================================
// Encodings
// ================================================

`define NOP_INST    32'h0000_0013   // ADDI x0, x0, 0

`endif

/* core_ifs.sv */
// Decoded instruction, decode register to execute
interface id_exe_if
    import core_pipe_pkg::*;
();

    logic     valid;
    reg_idx_t rd;
    reg_idx_t rs1;          // Kept for forwarding compares
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;      // Operand B from imm

    modport src (output valid, rd, rs1, rs2, rs1_data, rs2_data, imm, alu_op, use_imm);
    modport dst (input  valid, rd, rs1, rs2, rs1_data, rs2_data, imm, alu_op, use_imm);

endinterface

// Write-back result out of the execute register
interface wb_if
    import core_pipe_pkg::*;
();

    logic     valid;        // One retire per cycle at most
    logic     we;
    reg_idx_t rd;
    word_t    data;

    modport src  (output valid, we, rd, data);
    modport sink (input  valid, we, rd, data);

endinterface

/* core_pipe_pkg.sv */
`include "core_consts.svh"

package core_pipe_pkg;

    // ================================================
    // Data path words
    // ================================================

    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;   // x0 .. x31
    typedef logic [`XLEN-1:0]             word_t;

    // ================================================
    // ALU control
    // ================================================

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10      // Operand B straight through, for LUI
    } alu_op_t;

endpackage

/* core_top.f */
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
core_ifs.sv
inst_queue.sv
reg_file.sv
alu.sv
decode_stage.sv
exec_stage.sv
core_top.sv
tb_core_top.sv

/* core_top.sv */
module core_top
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    // Instruction stream, credit controlled
    input  logic     inst_valid_i,
    input  inst_t    inst_i,
    output logic     credit_o,

    // Retire port, no back-pressure
    output logic     retire_valid_o,
    output reg_idx_t retire_rd_o,
    output word_t    retire_data_o
);

    logic  head_valid;
    inst_t head_inst;

    id_exe_if i_id_exe ();
    wb_if     i_wb ();

    inst_queue i_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .credit_o     (credit_o)
    );

    decode_stage i_decode_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_inst_i  (head_inst),
        .wb           (i_wb.sink),
        .id_exe       (i_id_exe.src)
    );

    exec_stage i_exec_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .id_exe  (i_id_exe.dst),
        .wb      (i_wb.src)
    );

    // Retire straight off the write-back register
    assign retire_valid_o = i_wb.valid;
    assign retire_rd_o    = i_wb.rd;
    assign retire_data_o  = i_wb.data;

endmodule

/* decode_stage.sv */
`include "core_consts.svh"

module decode_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  head_valid_i,
    input  inst_t head_inst_i,
    wb_if.sink    wb,
    id_exe_if.src id_exe
);

    inst_t    inst;
    word_t    i_imm;
    word_t    u_imm;
    word_t    imm_d;
    alu_op_t  alu_op_d;
    logic     use_imm_d;
    logic     alt;
    reg_idx_t rd_d;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    rs1_data_d;
    word_t    rs2_data_d;

    function automatic alu_op_t f3_to_op(funct3_t f3, logic alt_op);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = alt_op ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt_op ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // ================================================
    // Field split and immediates
    // ================================================

    assign inst  = head_valid_i ? head_inst_i : inst_t'(`NOP_INST);    // Idle slot as a NOP
    assign alt   = inst.funct7[FUNCT7_ALT_BIT];
    assign i_imm = {{(`XLEN-12){inst.funct7[6]}}, inst.funct7, inst.rs2};
    assign u_imm = {inst.funct7, inst.rs2, inst.rs1, inst.funct3, 12'b0};

    always_comb begin
        alu_op_d  = ALU_ADD;
        use_imm_d = 1'b1;
        imm_d     = i_imm;
        rd_d      = inst.rd;
        rs1_d     = inst.rs1;
        rs2_d     = inst.rs2;
        case (inst.opcode)
            OP: begin
                alu_op_d  = f3_to_op(inst.funct3, alt);
                use_imm_d = 1'b0;
            end
            // Only the shift-right form has an alternate
            OP_IMM:  alu_op_d = f3_to_op(inst.funct3, alt && (inst.funct3 == F3_SRL_SRA));
            LUI: begin
                alu_op_d = ALU_PASS_B;
                imm_d    = u_imm;
            end
            default: begin      // Unsupported, retire without a write
                rd_d  = '0;
                rs1_d = '0;
                rs2_d = '0;
            end
        endcase
    end

    // ================================================
    // Operand read with write-back bypass
    // ================================================

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_d),
        .raddr2_i (rs2_d),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .wb       (wb)
    );

    assign rs1_data_d = (wb.we && (wb.rd != '0) && (wb.rd == rs1_d)) ? wb.data : rf_rdata1;
    assign rs2_data_d = (wb.we && (wb.rd != '0) && (wb.rd == rs2_d)) ? wb.data : rf_rdata2;

    // Decode to execute register, comes up holding a NOP
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_exe.valid    <= 1'b0;
            id_exe.rd       <= '0;
            id_exe.rs1      <= '0;
            id_exe.rs2      <= '0;
            id_exe.rs1_data <= '0;
            id_exe.rs2_data <= '0;
            id_exe.imm      <= '0;
            id_exe.alu_op   <= ALU_ADD;
            id_exe.use_imm  <= 1'b1;
        end else begin
            id_exe.valid    <= head_valid_i;
            id_exe.rd       <= rd_d;
            id_exe.rs1      <= rs1_d;
            id_exe.rs2      <= rs2_d;
            id_exe.rs1_data <= rs1_data_d;
            id_exe.rs2_data <= rs2_data_d;
            id_exe.imm      <= imm_d;
            id_exe.alu_op   <= alu_op_d;
            id_exe.use_imm  <= use_imm_d;
        end
    end

endmodule

/* exec_stage.sv */
module exec_stage
    import core_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    id_exe_if.dst id_exe,
    wb_if.src     wb
);

    logic  fwd_a_sel;
    logic  fwd_b_sel;
    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t alu_result;
    logic  we_d;

    // ================================================
    // Forwarding from the write-back register
    // ================================================

    // Result of the instruction right ahead, not yet in the register file
    assign fwd_a_sel = wb.we && (wb.rd != '0) && (wb.rd == id_exe.rs1);
    assign fwd_b_sel = wb.we && (wb.rd != '0) && (wb.rd == id_exe.rs2);

    assign op_a  = fwd_a_sel ? wb.data : id_exe.rs1_data;
    assign fwd_b = fwd_b_sel ? wb.data : id_exe.rs2_data;
    assign op_b  = id_exe.use_imm ? id_exe.imm : fwd_b;

    alu i_alu (
        .op_i     (id_exe.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    // ================================================
    // Execute to write-back register
    // ================================================

    assign we_d = id_exe.valid && (id_exe.rd != '0);   // Idle slots and x0 never write

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.valid <= 1'b0;
            wb.we    <= 1'b0;
            wb.rd    <= '0;
            wb.data  <= '0;
        end else begin
            wb.valid <= id_exe.valid;
            wb.we    <= we_d;
            wb.rd    <= id_exe.rd;
            wb.data  <= we_d ? alu_result : '0;    // Zero reported for non-writes
        end
    end

endmodule

/* inst_queue.sv */
`include "core_consts.svh"

module inst_queue
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  inst_valid_i,
    input  inst_t inst_i,
    output logic  head_valid_o,
    output inst_t head_inst_o,
    output logic  credit_o
);

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    inst_t            mem_ff [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_ff;
    logic [PTR_W-1:0] rd_ptr_ff;
    logic [CNT_W-1:0] count_ff;
    logic             credit_ff;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // Head leaves every cycle it exists since decode never stalls
    assign pop          = (count_ff != '0);
    assign head_valid_o = pop;
    assign head_inst_o  = mem_ff[rd_ptr_ff];
    assign credit_o     = credit_ff;

    // Entry storage filled on each accept
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            mem_ff[wr_ptr_ff] <= inst_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_ff <= '0;
            rd_ptr_ff <= '0;
            count_ff  <= '0;
            credit_ff <= 1'b0;
        end else begin
            if (inst_valid_i) begin
                wr_ptr_ff <= ptr_next(wr_ptr_ff);
            end
            if (pop) begin
                rd_ptr_ff <= ptr_next(rd_ptr_ff);
            end
            count_ff  <= count_ff + CNT_W'(inst_valid_i) - CNT_W'(pop);
            credit_ff <= pop;   // One credit back per hand-off
        end
    end

endmodule

/* reg_file.sv */
`include "core_consts.svh"

module reg_file
    import core_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o,
    wb_if.sink       wb
);

    // x0 has no storage
    word_t regs_ff [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs_ff[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs_ff[wb.rd] <= wb.data;
        end
    end

    // Asynchronous read ports
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_ff[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_ff[raddr2_i];

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,    // Register-register ALU
        OP_IMM = 7'b0010011,    // Register-immediate ALU
        LUI    = 7'b0110111
    } opcode_t;

    // ALU funct3 codes, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,    // funct7 bit 5 picks SRA
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // R-type field layout
    // I-type and U-type immediates are cut from the same bits
    typedef struct packed {
        logic [6:0] funct7;     // [31:25]
        logic [4:0] rs2;        // [24:20]
        logic [4:0] rs1;        // [19:15]
        funct3_t    funct3;     // [14:12]
        logic [4:0] rd;         // [11:7]
        opcode_t    opcode;     // [6:0]
    } inst_t;

    // Alternate-operation bit inside funct7 (SUB, SRA)
    localparam int unsigned FUNCT7_ALT_BIT = 5;

endpackage

/* tb_core_top.sv */
`include "core_consts.svh"

module tb_core_top
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
();

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } retire_rec_t;

    localparam int TIMEOUT_CYCLES = 100;

    // The ten R-type operations
    localparam funct3_t R_F3 [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                                      F3_XOR, F3_SRL_SRA, F3_SRL_SRA, F3_OR, F3_AND};
    localparam bit [9:0] R_ALT = 10'b00_1000_0010;    // SUB and SRA set funct7 bit 5

    logic     clk;
    logic     rst_n_i;
    logic     inst_valid_i;
    inst_t    inst_i;
    logic     credit_o;
    logic     retire_valid_o;
    reg_idx_t retire_rd_o;
    word_t    retire_data_o;

    word_t       model_regs [`NUM_REGS];
    retire_rec_t exp_q [$];             // Expected retires in send order
    retire_rec_t rec;
    int          sent_cnt;
    int          returned_cnt;
    int          err_cnt;
    int          tests_passed;
    int          tests_failed;
    int          seed;

    core_top i_core_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .credit_o       (credit_o),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #50 clk = ~clk;

    // ================================================
    // Compare tasks
    // ================================================

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rd(input string name, input reg_idx_t act, input reg_idx_t exp);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_data(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    // Retire and credit monitor
    always @(posedge clk) begin
        if (rst_n_i && credit_o) begin
            returned_cnt <= returned_cnt + 1;
        end
        if (rst_n_i && retire_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Retire at %0t with no instruction outstanding", $time);
                err_cnt++;
            end else begin
                rec = exp_q.pop_front();
                check_rd("retire_rd_o", retire_rd_o, rec.rd);
                check_data("retire_data_o", retire_data_o, rec.data);
            end
        end
    end

    // ================================================
    // Encoders and reference model
    // ================================================

    function automatic inst_t enc_r(input funct3_t f3, input bit alt, input int rd,
                                    input int rs1, input int rs2);
        return inst_t'({alt ? 7'b0100000 : 7'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP});
    endfunction

    function automatic inst_t enc_i(input funct3_t f3, input int rd, input int rs1,
                                    input int imm);
        return inst_t'({12'(imm), 5'(rs1), f3, 5'(rd), OP_IMM});
    endfunction

    function automatic inst_t enc_lui(input int rd, input int imm);
        return inst_t'({20'(imm), 5'(rd), LUI});
    endfunction

    // Predicts one retire and updates the model registers
    function automatic retire_rec_t predict(input inst_t inst);
        retire_rec_t r;
        word_t       a;
        word_t       b;
        a = model_regs[inst.rs1];
        b = (inst.opcode == OP) ? model_regs[inst.rs2]
                                : {{20{inst.funct7[6]}}, inst.funct7, inst.rs2};
        r.rd = (inst.opcode inside {OP, OP_IMM, LUI}) ? inst.rd : '0;
        case (inst.funct3)
            F3_ADD_SUB: r.data = (inst.opcode == OP && inst.funct7[5]) ? a - b : a + b;
            F3_SLL:     r.data = a << b[4:0];
            F3_SLT:     r.data = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    r.data = {31'b0, a < b};
            F3_XOR:     r.data = a ^ b;
            F3_SRL_SRA: r.data = (inst.funct7[5] && a[31]) ? ~(~a >> b[4:0]) : a >> b[4:0];
            F3_OR:      r.data = a | b;
            default:    r.data = a & b;
        endcase
        if (inst.opcode == LUI) begin
            r.data = {inst[31:12], 12'b0};
        end
        if (r.rd == '0) begin
            r.data = '0;        // Nothing written and zero reported
        end
        model_regs[r.rd] = r.data;
        return r;
    endfunction

    function automatic inst_t random_inst();
        word_t r;
        int    op;
        int    rd;
        int    imm;
        r  = $random(seed);
        op = int'(r[7:4]) % 10;
        rd = int'(r[15:12]) % 8;     // x0 now and then
        case (r[1:0])
            2'd0, 2'd1: return enc_r(R_F3[op], R_ALT[op], rd, int'(r[18:16]), int'(r[21:19]));
            2'd2: begin
                imm = (R_F3[op] inside {F3_SLL, F3_SRL_SRA})
                    ? (R_ALT[op] ? 'h400 : 0) + int'(r[26:22]) : int'(r[31:20]);
                return enc_i(R_F3[op], rd, int'(r[18:16]), imm);
            end
            default: return enc_lui(rd, int'(r[31:12]));
        endcase
    endfunction

    // ================================================
    // Drivers
    // ================================================

    // Waits for a credit and drives one instruction on the edge
    task automatic send(input inst_t inst);
        int waited;
        waited = 0;
        @(posedge clk);
        while (`QUEUE_DEPTH + returned_cnt - sent_cnt <= 0) begin
            inst_valid_i <= 1'b0;
            if (waited == TIMEOUT_CYCLES) begin
                $display("Timed out at %0t waiting for a credit", $time);
                err_cnt++;
                return;
            end
            waited++;
            @(posedge clk);
        end
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        sent_cnt++;
    endtask

    task automatic issue(input inst_t inst);
        exp_q.push_back(predict(inst));
        send(inst);
    endtask

    // Ends the stream and waits for every expected retire
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT_CYCLES) begin
                $display("Timed out at %0t with %0d retires missing", $time, exp_q.size());
                err_cnt++;
                exp_q.delete();
                return;
            end
            waited++;
            @(posedge clk);
        end
    endtask

    // Full word through LUI and ADDI
    // Upper part rounded for the sign-extended low part
    task automatic load_reg(input int rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;
        issue(enc_lui(rd, int'(upper[31:12])));
        issue(enc_i(F3_ADD_SUB, rd, rd, int'(value[11:0])));
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    // ================================================
    // Directed tests
    // ================================================

    task automatic test_reset();
        int errs;
        errs = err_cnt;
        repeat (6) begin
            @(posedge clk);
            check_bit("credit_o", credit_o, 1'b0);
            check_bit("retire_valid_o", retire_valid_o, 1'b0);
        end
        issue(enc_r(F3_ADD_SUB, 1'b0, 5, 1, 2));
        drain();
        report_test("reset state", errs);
    endtask

    task automatic test_imm();
        int errs;
        errs = err_cnt;
        issue(enc_i(F3_ADD_SUB, 1, 0, -1));
        issue(enc_i(F3_ADD_SUB, 2, 0, -2048));
        issue(enc_lui(3, 'habcde));
        issue(enc_i(F3_ADD_SUB, 3, 3, -291));
        issue(enc_i(F3_SLT, 4, 1, 0));
        issue(enc_i(F3_SLTU, 6, 1, -1));       // Equal operands give zero
        issue(enc_i(F3_SLTU, 7, 2, -1));
        issue(enc_i(F3_SLL, 8, 3, 4));
        issue(enc_i(F3_SRL_SRA, 9, 1, 28));
        issue(enc_i(F3_SRL_SRA, 10, 2, 'h403)); // SRAI by 3
        issue(enc_i(F3_XOR, 11, 3, -1));
        drain();
        report_test("immediate and LUI", errs);
    endtask

    task automatic test_reg_alu();
        int    errs;
        word_t r;
        errs = err_cnt;
        for (int k = 1; k <= 8; k++) begin
            load_reg(k, word_t'($random(seed)));
        end
        for (int k = 0; k < 20; k++) begin
            r = $random(seed);
            issue(enc_r(R_F3[k % 10], R_ALT[k % 10], 9 + k,
                        int'(r[2:0]) + 1, int'(r[5:3]) + 1));
        end
        drain();
        report_test("register ALU", errs);
    endtask

    task automatic test_forward();
        int    errs;
        int    op;
        word_t r;
        errs = err_cnt;
        issue(enc_i(F3_ADD_SUB, 1, 0, 5));
        issue(enc_r(F3_ADD_SUB, 1'b0, 2, 1, 1));   // Distance one
        issue(enc_r(F3_ADD_SUB, 1'b0, 3, 2, 1));   // Distance one and two
        issue(enc_r(F3_ADD_SUB, 1'b1, 4, 3, 2));
        issue(enc_r(F3_SLL, 1'b0, 5, 4, 1));
        issue(enc_i(F3_XOR, 5, 5, 'h5a5));
        // Each source is the result one back and two back
        for (int k = 0; k < 16; k++) begin
            r  = $random(seed);
            op = int'(r[7:4]) % 10;
            issue(enc_r(R_F3[op], R_ALT[op], 1 + k % 6, 1 + (k + 5) % 6, 1 + (k + 4) % 6));
        end
        drain();
        report_test("forwarding", errs);
    endtask

    task automatic test_credits();
        int errs;
        errs = err_cnt;
        check_count("credits held", `QUEUE_DEPTH + returned_cnt - sent_cnt, `QUEUE_DEPTH);
        for (int k = 1; k <= `QUEUE_DEPTH; k++) begin
            issue(enc_i(F3_ADD_SUB, k, 0, 100 + k));   // Distinct values show the order
        end
        // Whole burst in flight before its first credit comes back
        check_count("credits after burst", `QUEUE_DEPTH + returned_cnt - sent_cnt, 0);
        for (int k = 0; k < 60; k++) begin
            issue(random_inst());
        end
        drain();
        check_count("credit pulses", returned_cnt, sent_cnt);
        report_test("credits and order", errs);
    endtask

    task automatic test_x0();
        int errs;
        errs = err_cnt;
        issue(enc_i(F3_ADD_SUB, 0, 0, 123));
        issue(enc_r(F3_ADD_SUB, 1'b0, 0, 1, 3));
        issue(enc_r(F3_OR, 1'b0, 12, 0, 0));      // x0 still reads zero
        issue(inst_t'({7'd0, 5'd5, 5'd2, 3'b010, 5'd9, 7'b0100011}));    // SW
        issue(inst_t'({7'd0, 5'd3, 5'd1, 3'b000, 5'd10, 7'b1100011}));   // BEQ
        issue(enc_r(F3_ADD_SUB, 1'b0, 13, 9, 0));
        issue(enc_r(F3_ADD_SUB, 1'b0, 14, 10, 0));
        drain();
        report_test("x0 and unsupported opcodes", errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      <= 1'b0;
        inst_valid_i <= 1'b0;
        inst_i       <= inst_t'(`NOP_INST);
        seed         = 32'hddb1;
        sent_cnt     = 0;
        returned_cnt <= 0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset();
        test_imm();
        test_reg_alu();
        test_forward();
        test_credits();
        test_x0();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
